//--- Makefile
TOP = tb_eeprom_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module $(TOP) -f sim.f

run: compile
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf obj_dir

//--- sim.f
source/eeprom_pkg.sv
source/bus_pkg.sv
source/bus_event_if.sv
source/mem_port_if.sv
source/line_sampler.sv
source/bit_counter.sv
source/byte_shifter.sv
source/eeprom_fsm.sv
source/eeprom_array.sv
source/eeprom_top.sv
verification/i2c_master_bfm.sv
verification/tb_eeprom_top.sv

//--- source/bit_counter.sv
module bit_counter (
    input  logic                sda,
    input  logic                rst,
    bus_event_if.dst            ev,
    input  logic                clear,
    output bus_pkg::bit_count_t bit_count,
    output logic                byte_done
);

    bus_pkg::bit_count_t count;

    assign bit_count = count;
    assign byte_done = (count == bus_pkg::ACK_BIT);

    always_ff @(posedge sda)
    begin
        if (rst || clear || ev.start)
        begin
            count <= '0;
        end
        else if (ev.scl_rise)
        begin
            // ninth rise closes the frame
            if (count == bus_pkg::ACK_BIT)
            begin
                count <= '0;
            end
            else
            begin
                count <= count + 1'b1;
            end
        end
    end

endmodule

//--- source/bus_event_if.sv
// synchronized line events, each pulse lasts one sda cycle
interface bus_event_if;

    logic start;
    logic stop;
    logic scl_rise;
    logic scl_fall;
    logic sio_level;    // synchronized data level

    modport src
    (
        output start, stop, scl_rise, scl_fall, sio_level
    );

    modport dst
    (
        input start, stop, scl_rise, scl_fall, sio_level
    );

endinterface

//--- source/bus_pkg.sv
package bus_pkg;

    // bit position inside a nine clock frame
    typedef logic [3:0] bit_count_t;

    localparam logic [3:0] DEVICE_CODE = 4'b1010;

    // count value once eight data bits are in, ACK clock comes next
    localparam bit_count_t ACK_BIT = 4'd8;

    typedef enum logic [2:0]
    {
        IDLE,
        CTRL,       // receiving control byte
        ADDR,       // receiving word address
        WDATA,      // receiving write data
        RDATA,      // sending read data
        ACK_OUT,    // slave pulls the ACK bit low
        ACK_IN,     // master ACK or NACK after a read byte
        IGNORE      // not addressed, wait for start or stop
    } ctrl_state_t;

endpackage

//--- source/byte_shifter.sv
module byte_shifter (
    input  logic              sda,
    input  logic              rst,
    bus_event_if.dst          ev,
    input  logic              load,
    input  eeprom_pkg::data_t load_data,
    output eeprom_pkg::data_t rx_byte,
    output logic              tx_bit
);

    eeprom_pkg::data_t rx_q;
    eeprom_pkg::data_t tx_q;

    assign rx_byte = rx_q;
    assign tx_bit  = tx_q[7];   // msb first

    // sample on the rising clock, data is stable there
    always_ff @(posedge sda)
    begin
        if (ev.scl_rise)
        begin
            rx_q <= {rx_q[6:0], ev.sio_level};
        end
    end

    // shift on the falling clock so the bit holds through the high phase
    always_ff @(posedge sda)
    begin
        if (rst)
        begin
            tx_q <= '0;
        end
        else if (load)
        begin
            tx_q <= load_data;
        end
        else if (ev.scl_fall)
        begin
            tx_q <= {tx_q[6:0], 1'b0};
        end
    end

endmodule

//--- source/eeprom_array.sv
module eeprom_array (
    input  logic      sda,
    input  logic      rst,
    mem_port_if.slave mem
);

    eeprom_pkg::data_t mem_q [eeprom_pkg::MEM_DEPTH];
    logic              access;

    // one access per handshake, on the first req cycle
    assign access = mem.req && !mem.ack;

    initial
    begin
        for (int i = 0; i < eeprom_pkg::MEM_DEPTH; i++)
        begin
            mem_q[i] = '0;
        end
    end

    // ack follows req one cycle later, both ways
    always_ff @(posedge sda)
    begin
        if (rst)
        begin
            mem.ack <= 1'b0;
        end
        else
        begin
            mem.ack <= mem.req;
        end
    end

    always_ff @(posedge sda)
    begin
        if (access && mem.write)
            mem_q[mem.addr] <= mem.wdata;
        if (access && !mem.write)
            mem.rdata <= mem_q[mem.addr];
    end

    ack_needs_req: assert property (@(posedge sda) disable iff (rst)
        $rose(mem.ack) |-> mem.req);

endmodule

//--- source/eeprom_fsm.sv
module eeprom_fsm (
    input  logic                sda,
    input  logic                rst,
    bus_event_if.dst            ev,
    input  bus_pkg::bit_count_t bit_count,
    input  logic                byte_done,
    input  eeprom_pkg::data_t   rx_byte,
    input  logic                tx_bit,
    output logic                count_clear,
    output logic                load,
    mem_port_if.master          mem,
    output logic                sio_drive
);

    bus_pkg::ctrl_state_t   state;
    bus_pkg::ctrl_state_t   ack_from;   // byte that the pending ACK answers
    eeprom_pkg::mem_addr_t  ptr;
    eeprom_pkg::page_t      page;
    eeprom_pkg::word_addr_t word_addr;
    logic                   read_op;
    logic                   loaded;
    logic                   master_nack;
    logic                   byte_end;
    logic                   frame_end;
    logic                   fetch_start;
    logic                   store_start;

    assign word_addr = rx_byte;
    assign byte_end  = ev.scl_fall && byte_done;             // eighth data bit done
    assign frame_end = ev.scl_fall && (bit_count == '0);     // ACK clock done

    // fetch after the control byte ACK or after a master ACK
    assign fetch_start = frame_end &&
                         (((state == bus_pkg::ACK_OUT) && (ack_from == bus_pkg::CTRL) && read_op) ||
                          ((state == bus_pkg::ACK_IN) && !master_nack));
    assign store_start = (state == bus_pkg::WDATA) && byte_end;

    assign load        = mem.req && mem.ack && !mem.write;
    assign count_clear = (state == bus_pkg::IGNORE) && (ev.start || ev.stop);
    assign sio_drive   = (state == bus_pkg::ACK_OUT) ||
                         ((state == bus_pkg::RDATA) && loaded && !tx_bit);

    always_ff @(posedge sda)
    begin
        if (rst)
        begin
            state       <= bus_pkg::IDLE;
            ack_from    <= bus_pkg::IDLE;
            read_op     <= 1'b0;
            loaded      <= 1'b0;
            master_nack <= 1'b0;
            ptr         <= '0;
            mem.req     <= 1'b0;
        end
        else
        begin
            if (mem.req && mem.ack)
            begin
                mem.req <= 1'b0;
            end
            if (load)
            begin
                loaded <= 1'b1;
            end
            // pointer moves past each byte as its access starts
            if (fetch_start || store_start)
            begin
                mem.req <= 1'b1;
                ptr     <= ptr + 1'b1;
                loaded  <= 1'b0;
            end

            if (ev.stop)
            begin
                state <= bus_pkg::IDLE;
            end
            else if (ev.start)
            begin
                state <= bus_pkg::CTRL;    // also covers repeated start
            end
            else
            begin
                case (state)
                    bus_pkg::CTRL:
                    begin
                        if (byte_end)
                        begin
                            if (rx_byte[7:4] == bus_pkg::DEVICE_CODE)
                            begin
                                state    <= bus_pkg::ACK_OUT;
                                ack_from <= bus_pkg::CTRL;
                                read_op  <= rx_byte[0];
                            end
                            else
                            begin
                                state <= bus_pkg::IGNORE;
                            end
                        end
                    end
                    bus_pkg::ADDR:
                    begin
                        if (byte_end)
                        begin
                            state    <= bus_pkg::ACK_OUT;
                            ack_from <= bus_pkg::ADDR;
                            ptr      <= {page, word_addr};
                        end
                    end
                    bus_pkg::WDATA:
                    begin
                        if (byte_end)
                        begin
                            state    <= bus_pkg::ACK_OUT;
                            ack_from <= bus_pkg::WDATA;
                        end
                    end
                    bus_pkg::ACK_OUT:
                    begin
                        if (fetch_start)
                            state <= bus_pkg::RDATA;
                        else if (frame_end && (ack_from == bus_pkg::CTRL))
                            state <= bus_pkg::ADDR;
                        else if (frame_end)
                            state <= bus_pkg::WDATA;
                    end
                    bus_pkg::RDATA:
                    begin
                        if (byte_end)
                        begin
                            state <= bus_pkg::ACK_IN;
                        end
                    end
                    bus_pkg::ACK_IN:
                    begin
                        if (ev.scl_rise)
                            master_nack <= ev.sio_level;
                        if (fetch_start)
                            state <= bus_pkg::RDATA;
                        else if (frame_end)
                            state <= bus_pkg::IDLE;    // NACK ends the read
                    end
                    default:
                    begin
                        // idle and ignore only leave on start or stop
                    end
                endcase
            end
        end
    end

    // access payload captured as the request starts
    always_ff @(posedge sda)
    begin
        if ((state == bus_pkg::CTRL) && byte_end)
            page <= rx_byte[3:1];     // used by the word address only
        if (fetch_start || store_start)
        begin
            mem.write <= store_start;
            mem.addr  <= ptr;
            mem.wdata <= rx_byte;
        end
    end

    // req and its payload hold until the array answers
    req_held_for_ack: assert property (@(posedge sda) disable iff (rst)
        mem.req && !mem.ack |=> mem.req && $stable(mem.addr) && $stable(mem.write) &&
                                $stable(mem.wdata));

endmodule

//--- source/eeprom_pkg.sv
package eeprom_pkg;

    // storage size of the 24C16-style array
    localparam int MEM_DEPTH = 2048;

    // one stored byte
    typedef logic [7:0] data_t;

    // word address byte sent after a write control byte
    typedef logic [7:0] word_addr_t;

    // block select bits taken from the control byte
    typedef logic [2:0] page_t;

    // page bits sit above the word address
    typedef logic [$clog2(MEM_DEPTH)-1:0] mem_addr_t;

endpackage

//--- source/eeprom_top.sv
module eeprom_top #(
    parameter int SYNC_STAGES = 2
) (
    input  logic sda,
    input  logic rst,
    input  logic scl,
    input  logic sio,
    output logic sio_drive     // high pulls the line low
);

    bus_event_if ev_if ();
    mem_port_if  mem_if ();

    bus_pkg::bit_count_t bit_count;
    logic                byte_done;
    logic                count_clear;
    logic                load;
    eeprom_pkg::data_t   rx_byte;
    logic                tx_bit;

    line_sampler #(
        .SYNC_STAGES(SYNC_STAGES)
    ) sampler0 (
        .sda(sda), .rst(rst), .scl(scl), .sio(sio), .ev(ev_if.src)
    );

    bit_counter counter0 (
        .sda(sda), .rst(rst), .ev(ev_if.dst), .clear(count_clear),
        .bit_count(bit_count), .byte_done(byte_done)
    );

    // read data goes straight from the array into the shifter
    byte_shifter shifter0 (
        .sda(sda), .rst(rst), .ev(ev_if.dst), .load(load),
        .load_data(mem_if.rdata), .rx_byte(rx_byte), .tx_bit(tx_bit)
    );

    eeprom_fsm fsm0 (
        .sda(sda), .rst(rst), .ev(ev_if.dst), .bit_count(bit_count),
        .byte_done(byte_done), .rx_byte(rx_byte), .tx_bit(tx_bit),
        .count_clear(count_clear), .load(load), .mem(mem_if.master),
        .sio_drive(sio_drive)
    );

    eeprom_array array0 (
        .sda(sda), .rst(rst), .mem(mem_if.slave)
    );

endmodule

//--- source/line_sampler.sv
module line_sampler #(
    parameter int SYNC_STAGES = 2
) (
    input  logic     sda,
    input  logic     rst,
    input  logic     scl,
    input  logic     sio,
    bus_event_if.src ev
);

    logic [SYNC_STAGES-1:0] scl_sync;
    logic [SYNC_STAGES-1:0] sio_sync;
    logic                   scl_prev;
    logic                   sio_prev;
    logic                   scl_now;
    logic                   sio_now;

    assign scl_now      = scl_sync[SYNC_STAGES-1];
    assign sio_now      = sio_sync[SYNC_STAGES-1];
    assign ev.sio_level = sio_prev;    // lines up with the event pulses

    always_ff @(posedge sda)
    begin
        if (rst)
        begin
            scl_sync    <= '1;          // idle bus reads high
            sio_sync    <= '1;
            scl_prev    <= 1'b1;
            sio_prev    <= 1'b1;
            ev.scl_rise <= 1'b0;
            ev.scl_fall <= 1'b0;
            ev.start    <= 1'b0;
            ev.stop     <= 1'b0;
        end
        else
        begin
            scl_sync    <= {scl_sync[SYNC_STAGES-2:0], scl};
            sio_sync    <= {sio_sync[SYNC_STAGES-2:0], sio};
            scl_prev    <= scl_now;
            sio_prev    <= sio_now;
            ev.scl_rise <= scl_now && !scl_prev;
            ev.scl_fall <= !scl_now && scl_prev;
            // data moving while the clock stays high
            ev.start    <= scl_now && scl_prev && sio_prev && !sio_now;
            ev.stop     <= scl_now && scl_prev && !sio_prev && sio_now;
        end
    end

    // the raw clock was high as many cycles back as the sync chain delays it
    start_stop_excl: assert property (@(posedge sda) disable iff (rst)
        (ev.start || ev.stop) |-> !(ev.start && ev.stop) && $past(scl, SYNC_STAGES + 1));

endmodule

//--- source/mem_port_if.sv
// four-phase req/ack port into the memory array
interface mem_port_if;

    logic                  req;
    logic                  write;
    eeprom_pkg::mem_addr_t addr;
    eeprom_pkg::data_t     wdata;
    logic                  ack;
    eeprom_pkg::data_t     rdata;   // valid while ack is high

    modport master
    (
        output req, write, addr, wdata,
        input  ack, rdata
    );

    modport slave
    (
        input  req, write, addr, wdata,
        output ack, rdata
    );

endinterface

//--- verification/i2c_master_bfm.sv
module i2c_master_bfm #(
    parameter int HALF = 12     // sda cycles per scl phase
) (
    input  logic sda,
    input  logic sio,
    output logic scl,
    output logic sio_out        // low pulls the line, high releases it
);

    timeunit 1ns;
    timeprecision 1ns;

    initial
    begin
        scl     = 1'b1;
        sio_out = 1'b1;
    end

    // lines change a little after the clock edge
    task automatic step(input int n);
        repeat (n) @(posedge sda);
        #2;
    endtask

    // plain or repeated start, leaves scl low in mid phase
    task automatic start_cond();
        if (!scl)
        begin
            sio_out = 1'b1;
            step(HALF / 2);
            scl = 1'b1;
            step(HALF);
        end
        sio_out = 1'b0;
        step(HALF);
        scl = 1'b0;
        step(HALF / 2);
    endtask

    task automatic stop_cond();
        sio_out = 1'b0;
        step(HALF / 2);
        scl = 1'b1;
        step(HALF);
        sio_out = 1'b1;             // data rises with scl high
        step(HALF);
    endtask

    // one scl period, line sampled late in the high phase
    task automatic clock_bit(input logic b, output logic level);
        sio_out = b;
        step(HALF / 2);
        scl = 1'b1;
        step(HALF - 1);
        level = sio;
        step(1);
        scl = 1'b0;
        step(HALF / 2);
    endtask

    task automatic write_byte(input logic [7:0] data, output logic ack_level);
        logic unused;
        for (int i = 7; i >= 0; i--)
            clock_bit(data[i], unused);
        clock_bit(1'b1, ack_level);     // release for the slave ACK
    endtask

    task automatic read_byte(input logic nack, output logic [7:0] data);
        logic level;
        logic unused;
        data = '0;
        for (int i = 0; i < 8; i++)
        begin
            clock_bit(1'b1, level);
            data = {data[6:0], level};
        end
        clock_bit(nack, unused);
    endtask

endmodule

//--- verification/tb_eeprom_top.sv
module tb_eeprom_top;

    timeunit 1ns;
    timeprecision 1ns;

    localparam int NUM_TRANS  = 60;
    localparam int MAX_CYCLES = NUM_TRANS * 40 * 24 * 2;

    logic sda;
    logic rst;
    logic scl;
    logic sio;
    logic sio_out;
    logic sio_drive;
    int   seed = 32'hcc1c;
    int   cycles = 0;

    eeprom_pkg::data_t     ref_mem [eeprom_pkg::MEM_DEPTH];
    eeprom_pkg::mem_addr_t model_ptr;   // follows the slave address counter

    // open drain bus with pull-up
    assign sio = sio_out && !sio_drive;

    eeprom_top dut0 (
        .sda(sda), .rst(rst), .scl(scl), .sio(sio), .sio_drive(sio_drive)
    );

    i2c_master_bfm bfm0 (
        .sda(sda), .sio(sio), .scl(scl), .sio_out(sio_out)
    );

    task automatic report_failure();
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_data(input string name, input eeprom_pkg::data_t got,
                              input eeprom_pkg::data_t expected);
        if (got !== expected)
        begin
            $display("[FAIL] %s got 0x%h, expected 0x%h", name, got, expected);
            report_failure();
        end
    endtask

    task automatic check_ack(input string name, input logic got, input logic expected);
        if (got !== expected)
        begin
            $display("[FAIL] %s got 0x%h, expected 0x%h", name, got, expected);
            report_failure();
        end
    endtask

    function automatic eeprom_pkg::data_t control_byte(input logic [2:0] page, input logic rd);
        return {4'b1010, page, rd};
    endfunction

    // expect_level is the line level in the ACK clock (low is an ACK)
    task automatic send_byte(input eeprom_pkg::data_t data, input logic expect_level);
        logic level;
        bfm0.write_byte(data, level);
        check_ack("sio", level, expect_level);
    endtask

    task automatic set_pointer(input eeprom_pkg::mem_addr_t addr);
        bfm0.start_cond();
        send_byte(control_byte(addr[10:8], 1'b0), 1'b0);
        send_byte(addr[7:0], 1'b0);
        model_ptr = addr;
    endtask

    task automatic write_burst(input eeprom_pkg::mem_addr_t addr, input int n);
        eeprom_pkg::data_t data;
        set_pointer(addr);
        for (int i = 0; i < n; i++)
        begin
            data = eeprom_pkg::data_t'($random(seed));
            send_byte(data, 1'b0);
            ref_mem[model_ptr] = data;
            model_ptr++;                // wraps at 2048
        end
    endtask

    task automatic read_bytes(input int n);
        eeprom_pkg::data_t data;
        bfm0.start_cond();
        send_byte(control_byte(model_ptr[10:8], 1'b1), 1'b0);
        for (int i = 0; i < n; i++)
        begin
            bfm0.read_byte(i == n - 1, data);   // NACK on the last byte
            check_data("rdata", data, ref_mem[model_ptr]);
            model_ptr++;
        end
    endtask

    task automatic wrong_code_access(input logic [3:0] code);
        logic [3:0] bad;
        bad = (code == 4'b1010) ? ~code : code;
        bfm0.start_cond();
        send_byte({bad, model_ptr[10:8], 1'b0}, 1'b1);
        send_byte(eeprom_pkg::data_t'($random(seed)), 1'b1);  // must not reach memory
    endtask

    task automatic stop_and_check_idle();
        bfm0.stop_cond();
        repeat (4)
        begin
            @(posedge sda);
            #2;
            check_ack("sio_drive", sio_drive, 1'b0);
        end
    endtask

    initial
    begin
        sda = 1'b0;
        forever #10 sda = ~sda;
    end

    always @(posedge sda)
    begin
        cycles++;
        if (cycles > MAX_CYCLES)
        begin
            $display("timeout after %0d cycles, transactions did not complete", cycles);
            report_failure();
        end
    end

    initial
    begin
        logic [31:0]           r;
        eeprom_pkg::mem_addr_t addr;
        rst       = 1'b1;
        model_ptr = '0;
        for (int i = 0; i < eeprom_pkg::MEM_DEPTH; i++)
            ref_mem[i] = '0;
        repeat (2) @(posedge sda);
        #2;
        rst = 1'b0;
        repeat (4) @(posedge sda);
        #2;
        // bursts across the top of memory
        write_burst(11'h7fe, 4);
        stop_and_check_idle();
        set_pointer(11'h7fe);
        read_bytes(4);
        stop_and_check_idle();
        for (int t = 0; t < NUM_TRANS; t++)
        begin
            r = $random(seed);
            // a quarter of the addresses sit at the top so bursts wrap
            if (r[9:8] == 2'b00)
                addr = {8'hff, r[12:10]};
            else
                addr = eeprom_pkg::mem_addr_t'($random(seed));
            case (r[2:0])
                3'd3:
                begin
                    set_pointer(addr);
                    read_bytes(1);      // random read
                end
                3'd4:
                begin
                    set_pointer(addr);
                    read_bytes(2 + int'(r[4:3]));
                end
                3'd5: read_bytes(1 + int'(r[4]));  // current address
                3'd6: wrong_code_access(r[7:4]);
                default: write_burst(addr, 1 + int'(r[4:3]));
            endcase
            stop_and_check_idle();
        end
        $display("Simulation passed");
        $finish;
    end

endmodule
